/* sources.f */
src/sf_video_pkg.sv
src/video_timing.sv
src/layer_priority.sv
src/colour_prom.sv
src/video_out.sv
src/slapfight_video.sv
tests/tb_slapfight_video.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_slapfight_video
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?=
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -e '=== PASS ==='

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_slapfight_video.sv */
`timescale 1ns/100ps

module tb_slapfight_video
	import sf_video_pkg::*;
();

	localparam int CLK_PERIOD  = 8;
	localparam int PRIO_PIXELS = 2000;
	localparam int RUN_FRAMES  = 2;	// frames the whole run needs
	localparam int WATCHDOG_NS = RUN_FRAMES * V_TOTAL * H_TOTAL * CLK_PERIOD * 3 / 2;

	// order is hsync, hblank, vsync, vblank
	localparam int EXP_HIGH [4] = '{
		H_SYNC_END - H_SYNC_START,
		H_TOTAL - H_VISIBLE,
		(V_SYNC_END - V_SYNC_START) * H_TOTAL,
		(V_TOTAL - V_VISIBLE) * H_TOTAL
	};
	localparam int EXP_PERIOD [4] = '{H_TOTAL, H_TOTAL, V_TOTAL * H_TOTAL, V_TOTAL * H_TOTAL};

	logic      pixel_clk;
	logic      RESET_n;
	logic      flip_i;
	dl_t       dl_i;
	layer_px_t layers_i;
	beam_t     beam_o;
	rgb_t      rgb_o;
	beam_t     sync_o;

	integer   seed;
	int       errors = 0;
	int       checks = 0;
	logic     check_en;
	channel_t prom_ref [NUM_CHANNELS][256];	// expected prom contents
	rgb_t     exp_rgb [OUT_LATENCY];
	logic     exp_vld [OUT_LATENCY];
	int       rises [4];
	int       h_ref;	// expected beam counters
	int       v_ref;
	logic     flip_ref;
	beam_t    exp_beam [OUT_LATENCY];

	slapfight_video uut (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip_i),
		.dl_i      (dl_i),
		.layers_i  (layers_i),
		.beam_o    (beam_o),
		.rgb_o     (rgb_o),
		.sync_o    (sync_o)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// transparent pens are 0 in the low 2 bits of fg and the low 4 bits of sp
	function automatic rgb_t ref_rgb(input layer_px_t px);
		colour_idx_t idx;
		rgb_t        res;
		if (px.fg[1:0] != 2'b00)
			idx = px.fg;
		else if (px.sp[3:0] != 4'h0)
			idx = px.sp;
		else
			idx = px.bg;
		res.r = prom_ref[0][idx];
		res.g = prom_ref[1][idx];
		res.b = prom_ref[2][idx];
		return res;
	endfunction

	// beam for one counter position, mirrored when flipped
	function automatic beam_t ref_beam(input int h, input int v, input logic flip);
		beam_t b;
		b.hpix   = flip ? 8'(255 - h) : 8'(h);
		b.vpix   = flip ? 8'(255 - v) : 8'(v);
		b.hblank = (h >= H_VISIBLE);
		b.vblank = (v >= V_VISIBLE);
		b.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_END);
		b.vsync  = (v >= V_SYNC_START) && (v < V_SYNC_END);
		return b;
	endfunction

	// ==============================
	// expected pixel pipeline and compare
	// ==============================
	always @(posedge pixel_clk) begin
		exp_rgb[0] <= ref_rgb(layers_i);
		exp_vld[0] <= check_en;
		for (int i = 1; i < OUT_LATENCY; i++) begin
			exp_rgb[i] <= exp_rgb[i-1];
			exp_vld[i] <= exp_vld[i-1];
		end
	end

	initial begin : compare_rgb
		forever begin
			@(negedge pixel_clk);
			if (exp_vld[OUT_LATENCY-1])
				check("rgb_o", 32'(rgb_o), 32'(exp_rgb[OUT_LATENCY-1]));
		end
	end

	// expected beam position and its copy three pixels later
	always @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_ref    <= 0;
			v_ref    <= 0;
			flip_ref <= 1'b0;
			for (int i = 0; i < OUT_LATENCY; i++)
				exp_beam[i] <= '0;
		end else begin
			if (h_ref == 0 && v_ref == 0)
				flip_ref <= flip_i;	// taken at the top left corner
			if (h_ref == H_TOTAL - 1) begin
				h_ref <= 0;
				v_ref <= (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
			end else begin
				h_ref <= h_ref + 1;
			end
			exp_beam[0] <= ref_beam(h_ref, v_ref, flip_ref);
			for (int i = 1; i < OUT_LATENCY; i++)
				exp_beam[i] <= exp_beam[i-1];
		end
	end

	initial begin : compare_beam
		@(posedge RESET_n);
		forever begin
			@(negedge pixel_clk);
			check("beam_o", 32'(beam_o), 32'(ref_beam(h_ref, v_ref, flip_ref)));
			check("sync_o", 32'(sync_o), 32'(exp_beam[OUT_LATENCY-1]));
		end
	end

	// pulse widths and periods seen on sync_o
	initial begin : timing_monitor
		logic [3:0] now;
		logic [3:0] prev;
		int         high_cnt [4];
		int         since_rise [4];
		string      sig_name [4];
		sig_name = '{"hsync", "hblank", "vsync", "vblank"};
		prev = '0;
		for (int s = 0; s < 4; s++) begin
			high_cnt[s]   = 0;
			since_rise[s] = 0;
			rises[s]      = 0;
		end
		@(posedge RESET_n);
		forever begin
			@(negedge pixel_clk);
			now = {sync_o.vblank, sync_o.vsync, sync_o.hblank, sync_o.hsync};
			for (int s = 0; s < 4; s++) begin
				since_rise[s]++;
				if (now[s])
					high_cnt[s]++;
				if (now[s] && !prev[s]) begin
					if (rises[s] > 0)
						check($sformatf("%s period", sig_name[s]), since_rise[s], EXP_PERIOD[s]);
					rises[s]++;
					since_rise[s] = 0;
				end
				if (!now[s] && prev[s]) begin
					check($sformatf("%s width", sig_name[s]), high_cnt[s], EXP_HIGH[s]);
					high_cnt[s] = 0;
				end
			end
			prev = now;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// ==============================
	// stimulus
	// ==============================
	task automatic reset_and_check();
		repeat (3) begin
			@(negedge pixel_clk);
			check("rgb_o in reset", 32'(rgb_o), 32'd0);
			check("sync_o in reset", 32'(sync_o), 32'd0);
		end
		RESET_n = 1'b1;
		@(negedge pixel_clk);
		check("rgb_o after reset", 32'(rgb_o), 32'd0);
		check("sync_o after reset", 32'(sync_o), 32'd0);
	endtask

	task automatic load_proms();
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			for (int idx = 0; idx < 256; idx++) begin
				@(negedge pixel_clk);
				r = $random(seed);
				dl_i.addr = PROM_BASE[ch] | DL_ADDR_W'(idx);
				dl_i.data = r[7:0];
				dl_i.wr   = 1'b1;
				prom_ref[ch][idx] = r[3:0];	// high nibble is dropped
			end
		end
		@(negedge pixel_clk);
		dl_i.wr = 1'b0;
	endtask

	task automatic read_back_all();
		for (int idx = 0; idx < 256; idx++) begin
			@(negedge pixel_clk);
			layers_i    = '0;
			layers_i.bg = colour_idx_t'(idx);
			check_en    = 1'b1;
		end
	endtask

	task automatic random_priority();
		logic [31:0] r;
		layer_px_t   px;
		for (int i = 0; i < PRIO_PIXELS; i++) begin
			@(negedge pixel_clk);
			r  = $random(seed);
			px = r[23:0];
			if (r[30])
				px.fg[1:0] = 2'b00;	// let sprites through
			if (r[31])
				px.sp[3:0] = 4'h0;
			layers_i = px;
		end
		@(negedge pixel_clk);
		check_en = 1'b0;
		repeat (OUT_LATENCY) @(negedge pixel_clk);	// drain the pipe
	endtask

	// returns at the first pixel of a new frame
	task automatic wait_frame_start();
		logic was_blank;
		logic found;
		was_blank = 1'b0;
		found     = 1'b0;
		while (!found) begin
			@(negedge pixel_clk);
			found     = was_blank && !beam_o.vblank;
			was_blank = beam_o.vblank;
		end
	endtask

	task automatic check_flip_frame();
		@(negedge pixel_clk);
		flip_i = 1'b1;
		wait_frame_start();
		for (int line = 0; line < V_VISIBLE; line++) begin
			for (int px = 0; px < H_TOTAL; px++) begin
				// flip is taken while the top left pixel is on screen
				if (px < H_VISIBLE && !(line == 0 && px == 0)) begin
					check("flip hpix", 32'(beam_o.hpix), 255 - px);
					check("flip vpix", 32'(beam_o.vpix), 255 - line);
				end
				@(negedge pixel_clk);
			end
		end
	endtask

	initial begin : main
		seed     = 32'h73d11c6b;
		RESET_n  = 1'b0;
		flip_i   = 1'b0;
		dl_i     = '0;
		layers_i = '0;
		check_en = 1'b0;

		reset_and_check();
		load_proms();
		read_back_all();
		random_priority();
		check_flip_frame();
		wait_frame_start();	// second vsync and vblank are behind us here
		check("vsync pulses seen", 32'(rises[2] >= 2), 32'd1);
		check("vblank pulses seen", 32'(rises[3] >= 2), 32'd1);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* src/slapfight_video.sv */
`timescale 1ns/100ps

module slapfight_video
	import sf_video_pkg::*;
(
	input  logic      pixel_clk,
	input  logic      RESET_n,
	input  logic      flip_i,
	input  dl_t       dl_i,
	input  layer_px_t layers_i,
	output beam_t     beam_o,
	output rgb_t      rgb_o,
	output beam_t     sync_o
);

	colour_idx_t colour_idx;
	channel_t    channels [NUM_CHANNELS];

	// ==============================
	// beam timing
	// ==============================
	video_timing u_timing (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.flip_i    (flip_i),
		.beam_o    (beam_o)	// also goes out to the layer sources
	);

	layer_priority u_priority (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.layers_i     (layers_i),
		.colour_idx_o (colour_idx)
	);

	// red, green, blue proms
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_prom
		colour_prom #(
			.CHANNEL (ch)
		) u_prom (
			.pixel_clk    (pixel_clk),
			.RESET_n      (RESET_n),
			.dl_i         (dl_i),
			.colour_idx_i (colour_idx),
			.channel_o    (channels[ch])
		);
	end

	// ==============================
	// aligned output
	// ==============================
	video_out u_out (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.channels_i (channels),
		.beam_i     (beam_o),
		.rgb_o      (rgb_o),
		.sync_o     (sync_o)
	);

endmodule

/* src/video_out.sv */
`timescale 1ns/100ps

module video_out
	import sf_video_pkg::*;
(
	input  logic     pixel_clk,
	input  logic     RESET_n,
	input  channel_t channels_i [NUM_CHANNELS],
	input  beam_t    beam_i,
	output rgb_t     rgb_o,
	output beam_t    sync_o
);

	beam_t beam_dly [OUT_LATENCY];

	// ==============================
	// pixel output register
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rgb_o <= '0;
		end else begin
			rgb_o.r <= channels_i[0];
			rgb_o.g <= channels_i[1];
			rgb_o.b <= channels_i[2];
		end
	end

	// beam delay line, one stage per register on the pixel path
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			for (int i = 0; i < OUT_LATENCY; i++)
				beam_dly[i] <= '0;
		end else begin
			beam_dly[0] <= beam_i;
			for (int i = 1; i < OUT_LATENCY; i++)
				beam_dly[i] <= beam_dly[i-1];
		end
	end

	assign sync_o = beam_dly[OUT_LATENCY-1];

	// sync pulse has to sit inside the blanking window on the output
	hsync_in_blank: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		sync_o.hsync |-> sync_o.hblank
	) else $error("hsync outside hblank");

endmodule

/* src/colour_prom.sv */
`timescale 1ns/100ps

module colour_prom
	import sf_video_pkg::*;
#(
	parameter int CHANNEL = 0	// index into PROM_BASE
)(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  dl_t         dl_i,
	input  colour_idx_t colour_idx_i,
	output channel_t    channel_o
);

	localparam int DEPTH = 2 ** $bits(colour_idx_t);

	channel_t mem [DEPTH];
	logic     region_hit;

	// each prom owns one 256 byte page of the download space
	assign region_hit = (dl_i.addr[DL_ADDR_W-1:8] == PROM_BASE[CHANNEL][DL_ADDR_W-1:8]);

	// ==============================
	// download write port
	// ==============================
	always_ff @(posedge pixel_clk) begin
		if (dl_i.wr && region_hit)
			mem[dl_i.addr[7:0]] <= dl_i.data[3:0];	// only low nibble is wired
	end

	// registered lookup, old data on a same cycle write
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			channel_o <= '0;
		else
			channel_o <= mem[colour_idx_i];
	end

	dl_addr_known: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		dl_i.wr |-> !$isunknown(dl_i.addr)
	) else $error("download strobe with unknown address");

endmodule

/* src/layer_priority.sv */
`timescale 1ns/100ps

module layer_priority
	import sf_video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  layer_px_t   layers_i,
	output colour_idx_t colour_idx_o
);

	logic fg_opaque;
	logic sp_opaque;

	// pen 0 is transparent on the board
	assign fg_opaque = |layers_i.fg[1:0];	// fg uses 2 bit pens
	assign sp_opaque = |layers_i.sp[3:0];	// sprites use 4 bit pens

	// ==============================
	// foreground over sprites over background
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			colour_idx_o <= '0;
		else if (fg_opaque)
			colour_idx_o <= layers_i.fg;
		else if (sp_opaque)
			colour_idx_o <= layers_i.sp;
		else
			colour_idx_o <= layers_i.bg;	// background always shows
	end

endmodule

/* src/video_timing.sv */
`timescale 1ns/100ps

module video_timing
	import sf_video_pkg::*;
(
	input  logic  pixel_clk,
	input  logic  RESET_n,
	input  logic  flip_i,
	output beam_t beam_o
);

	logic [H_CNT_W-1:0] hcount;
	logic [V_CNT_W-1:0] vcount;
	logic               flip_q;
	logic               line_end;
	logic               frame_end;
	logic               frame_start;

	assign line_end    = (hcount == H_CNT_W'(H_TOTAL - 1));
	assign frame_end   = (vcount == V_CNT_W'(V_TOTAL - 1));
	assign frame_start = (hcount == '0) && (vcount == '0);

	// ==============================
	// pixel and line counters
	// ==============================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			if (line_end) begin
				hcount <= '0;
				if (frame_end)
					vcount <= '0;
				else
					vcount <= vcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// screen flip only changes at the top left corner
	// so a frame is never drawn half flipped
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			flip_q <= 1'b0;
		else if (frame_start)
			flip_q <= flip_i;
	end

	// ==============================
	// beam decode
	// ==============================
	always_comb begin
		beam_o = '0;

		if (flip_q) begin
			beam_o.hpix = 8'd255 - hcount[7:0];	// mirrored scan
			beam_o.vpix = 8'd255 - vcount[7:0];
		end else begin
			beam_o.hpix = hcount[7:0];
			beam_o.vpix = vcount[7:0];
		end

		beam_o.hblank = (hcount >= H_CNT_W'(H_VISIBLE));
		beam_o.vblank = (vcount >= V_CNT_W'(V_VISIBLE));

		beam_o.hsync = (hcount >= H_CNT_W'(H_SYNC_START)) &&
			(hcount < H_CNT_W'(H_SYNC_END));
		beam_o.vsync = (vcount >= V_CNT_W'(V_SYNC_START)) &&
			(vcount < V_CNT_W'(V_SYNC_END));
	end

	// the last pixel of a line must always fold back to zero
	hcount_wrap: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		hcount >= H_CNT_W'(H_TOTAL - 1) |=> hcount == '0
	) else $error("hcount ran past H_TOTAL");

endmodule

/* src/sf_video_pkg.sv */
package sf_video_pkg;

	// ==============================
	// beam timing, one pixel per pixel_clk
	// ==============================
	localparam int H_TOTAL      = 384;
	localparam int H_VISIBLE    = 256;
	localparam int H_SYNC_START = 288;
	localparam int H_SYNC_END   = 320;	// first pixel after hsync

	localparam int V_TOTAL      = 264;
	localparam int V_VISIBLE    = 224;
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_END   = 243;	// first line after vsync

	localparam int H_CNT_W = 9;	// holds 0..383
	localparam int V_CNT_W = 9;	// holds 0..263

	// colour proms and download
	localparam int NUM_CHANNELS = 3;
	localparam int DL_ADDR_W    = 10;
	localparam logic [DL_ADDR_W-1:0] PROM_BASE [NUM_CHANNELS] = '{
		10'h000,	// red
		10'h100,	// green
		10'h200		// blue
	};

	localparam int OUT_LATENCY = 3;	// layer in to rgb out

	typedef logic [7:0] colour_idx_t;
	typedef logic [3:0] channel_t;

	typedef struct packed {
		colour_idx_t fg;
		colour_idx_t sp;
		colour_idx_t bg;
	} layer_px_t;

	typedef struct packed {
		logic [7:0] hpix;
		logic [7:0] vpix;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} beam_t;

	typedef struct packed {
		channel_t r;
		channel_t g;
		channel_t b;
	} rgb_t;

	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
		logic                 wr;	// one-cycle strobe
	} dl_t;

endpackage
